//--- logic/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0] reg_idx_t;

  // codes 9 to 15 decode as no-ops
  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_and  = 4'h2,
    op_or   = 4'h3,
    op_xor  = 4'h4,
    op_addi = 4'h5,
    op_lw   = 4'h6,
    op_sw   = 4'h7,
    op_beq  = 4'h8
  } opcode_e;

  typedef enum logic {
    owner_fetch = 1'b0,
    owner_data  = 1'b1
  } bus_owner_e;

  localparam word_t reset_pc = 32'h0000_0000;
  localparam word_t pc_step  = 32'd4;

  // instruction field positions
  localparam int op_hi  = 31;
  localparam int op_lo  = 28;
  localparam int rd_hi  = 27;
  localparam int rd_lo  = 24;
  localparam int rs1_hi = 23;
  localparam int rs1_lo = 20;
  localparam int rs2_hi = 19;
  localparam int rs2_lo = 16;
  localparam int imm_hi = 15;
  localparam int imm_lo = 0;

  // true for instructions that leave a result in rd
  function automatic logic writes_rd(opcode_e op);
    return op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi, op_lw};
  endfunction

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/1ns
module fetch_stage (
  input  logic            clk,
  input  logic            reset,
  output logic            inst_req,
  output core_pkg::word_t inst_addr,
  input  logic            inst_addr_ok,
  input  logic            inst_data_ok,
  input  core_pkg::word_t inst_rdata,
  input  logic            redirect,
  input  core_pkg::word_t redirect_pc,
  input  logic            ds_allowin,
  output logic            fs2ds_valid,
  output core_pkg::word_t fs2ds_pc,
  output core_pkg::word_t fs2ds_inst
);

  core_pkg::word_t pc;  // address of the next request
  logic wait_q;         // request accepted, instruction not back yet
  logic drop_q;         // the outstanding request is on the wrong path
  logic issue;

  // one request at a time, and only when the buffer has room for its answer
  assign issue = !inst_req && !wait_q && (!fs2ds_valid || ds_allowin) && !redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= core_pkg::reset_pc;
      inst_req    <= 1'b0;
      wait_q      <= 1'b0;
      drop_q      <= 1'b0;
      fs2ds_valid <= 1'b0;
    end else begin
      if (redirect) begin
        pc <= redirect_pc;
      end else if (issue) begin
        pc <= pc + core_pkg::pc_step;
      end

      if (issue) begin
        inst_req <= 1'b1;
      end else if (inst_addr_ok) begin
        inst_req <= 1'b0;
      end

      if (inst_req && inst_addr_ok) begin
        wait_q <= 1'b1;
      end else if (inst_data_ok) begin
        wait_q <= 1'b0;
      end

      // anything still on the bus at a redirect comes back stale
      if (redirect) begin
        drop_q <= inst_req || (wait_q && !inst_data_ok);
      end else if (inst_data_ok) begin
        drop_q <= 1'b0;
      end

      if (redirect) begin
        fs2ds_valid <= 1'b0;
      end else if (inst_data_ok && !drop_q) begin
        fs2ds_valid <= 1'b1;
      end else if (ds_allowin) begin
        fs2ds_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      inst_addr <= pc;
    end
    if (inst_data_ok && !drop_q) begin
      fs2ds_pc   <= inst_addr;  // inst_addr still names the returning request
      fs2ds_inst <= inst_rdata;
    end
  end

  a_addr_held: assert property (@(posedge clk) disable iff (reset)
    inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr));

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ns
module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fs2ds_valid,
  input  core_pkg::word_t      fs2ds_pc,
  input  core_pkg::word_t      fs2ds_inst,
  output logic                 ds_allowin,
  input  logic                 flush,
  output core_pkg::reg_idx_t   rf_raddr1,
  output core_pkg::reg_idx_t   rf_raddr2,
  input  core_pkg::word_t      rf_rdata1,
  input  core_pkg::word_t      rf_rdata2,
  input  logic                 es_dest_valid,
  input  core_pkg::reg_idx_t   es_dest,
  input  logic                 ws_dest_valid,
  input  core_pkg::reg_idx_t   ws_dest,
  input  logic                 es_allowin,
  output logic                 ds2es_valid,
  output core_pkg::word_t      ds2es_pc,
  output core_pkg::opcode_e    ds2es_op,
  output core_pkg::reg_idx_t   ds2es_rd,
  output core_pkg::word_t      ds2es_a,
  output core_pkg::word_t      ds2es_b,
  output core_pkg::word_t      ds2es_imm
);

  logic            ds_valid;
  core_pkg::word_t ds_inst;
  logic            use_rs1;
  logic            use_rs2;
  logic            hit1;
  logic            hit2;
  logic            ds_ready_go;

  assign ds2es_op  = core_pkg::opcode_e'(ds_inst[core_pkg::op_hi:core_pkg::op_lo]);
  assign ds2es_rd  = ds_inst[core_pkg::rd_hi:core_pkg::rd_lo];
  assign rf_raddr1 = ds_inst[core_pkg::rs1_hi:core_pkg::rs1_lo];
  assign rf_raddr2 = ds_inst[core_pkg::rs2_hi:core_pkg::rs2_lo];
  assign ds2es_imm = {{16{ds_inst[core_pkg::imm_hi]}},
                      ds_inst[core_pkg::imm_hi:core_pkg::imm_lo]};
  assign ds2es_a   = rf_rdata1;
  assign ds2es_b   = rf_rdata2;

  // rs1 is the base for loads and stores, rs2 the store data
  assign use_rs1 = ds2es_op inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
                                    core_pkg::op_or, core_pkg::op_xor, core_pkg::op_addi,
                                    core_pkg::op_lw, core_pkg::op_sw, core_pkg::op_beq};
  assign use_rs2 = ds2es_op inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
                                    core_pkg::op_or, core_pkg::op_xor, core_pkg::op_sw,
                                    core_pkg::op_beq};

  // no forwarding, so wait until the writer has left writeback
  assign hit1 = (rf_raddr1 != '0) && ((es_dest_valid && es_dest == rf_raddr1) ||
                                      (ws_dest_valid && ws_dest == rf_raddr1));
  assign hit2 = (rf_raddr2 != '0) && ((es_dest_valid && es_dest == rf_raddr2) ||
                                      (ws_dest_valid && ws_dest == rf_raddr2));

  assign ds_ready_go = !(use_rs1 && hit1) && !(use_rs2 && hit2);
  assign ds_allowin  = !ds_valid || (ds_ready_go && es_allowin);
  assign ds2es_valid = ds_valid && ds_ready_go && !flush;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= fs2ds_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fs2ds_valid && ds_allowin) begin
      ds2es_pc <= fs2ds_pc;
      ds_inst  <= fs2ds_inst;
    end
  end

endmodule

//--- logic/exec_stage.sv
`timescale 1ns/1ns
module exec_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ds2es_valid,
  input  core_pkg::word_t      ds2es_pc,
  input  core_pkg::opcode_e    ds2es_op,
  input  core_pkg::reg_idx_t   ds2es_rd,
  input  core_pkg::word_t      ds2es_a,
  input  core_pkg::word_t      ds2es_b,
  input  core_pkg::word_t      ds2es_imm,
  output logic                 es_allowin,
  output logic                 redirect,
  output core_pkg::word_t      redirect_pc,
  output logic                 data_req,
  output logic                 data_wr,
  output core_pkg::word_t      data_addr,
  output core_pkg::word_t      data_wdata,
  input  logic                 data_addr_ok,
  output logic                 es_dest_valid,
  output core_pkg::reg_idx_t   es_dest,
  input  logic                 ws_allowin,
  output logic                 es2ws_valid,
  output core_pkg::word_t      es2ws_pc,
  output core_pkg::opcode_e    es2ws_op,
  output core_pkg::reg_idx_t   es2ws_rd,
  output core_pkg::word_t      es2ws_result
);

  logic            es_valid;
  core_pkg::word_t es_a;
  core_pkg::word_t es_b;
  core_pkg::word_t es_imm;
  logic            is_mem;
  logic            mem_done;  // the bus has taken this load or store
  logic            es_ready_go;

  always_comb begin
    case (es2ws_op)
      core_pkg::op_add:  es2ws_result = es_a + es_b;
      core_pkg::op_sub:  es2ws_result = es_a - es_b;
      core_pkg::op_and:  es2ws_result = es_a & es_b;
      core_pkg::op_or:   es2ws_result = es_a | es_b;
      core_pkg::op_xor:  es2ws_result = es_a ^ es_b;
      core_pkg::op_addi,
      core_pkg::op_lw,
      core_pkg::op_sw:   es2ws_result = es_a + es_imm;
      default:           es2ws_result = '0;
    endcase
  end

  assign is_mem      = es2ws_op inside {core_pkg::op_lw, core_pkg::op_sw};
  assign data_req    = es_valid && is_mem && !mem_done;
  assign data_wr     = es2ws_op == core_pkg::op_sw;
  assign data_addr   = es2ws_result;
  assign data_wdata  = es_b;

  assign es_ready_go = !is_mem || mem_done || data_addr_ok;
  assign es_allowin  = !es_valid || (es_ready_go && ws_allowin);
  assign es2ws_valid = es_valid && es_ready_go;

  // taken branch strobes once, on the cycle it moves on to writeback
  assign redirect    = es_valid && es2ws_op == core_pkg::op_beq && es_a == es_b && ws_allowin;
  assign redirect_pc = es2ws_pc + core_pkg::pc_step + {es_imm[29:0], 2'b00};

  assign es_dest_valid = es_valid && core_pkg::writes_rd(es2ws_op) && es2ws_rd != '0;
  assign es_dest       = es2ws_rd;

  always_ff @(posedge clk) begin
    if (reset) begin
      es_valid <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      if (es_allowin) begin
        es_valid <= ds2es_valid;
      end
      if (es_allowin) begin
        mem_done <= 1'b0;
      end else if (data_req && data_addr_ok) begin
        mem_done <= 1'b1;  // writeback is still busy, keep the request from repeating
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ds2es_valid && es_allowin) begin
      es2ws_pc <= ds2es_pc;
      es2ws_op <= ds2es_op;
      es2ws_rd <= ds2es_rd;
      es_a     <= ds2es_a;
      es_b     <= ds2es_b;
      es_imm   <= ds2es_imm;
    end
  end

endmodule

//--- logic/writeback_stage.sv
`timescale 1ns/1ns
module writeback_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 es2ws_valid,
  input  core_pkg::word_t      es2ws_pc,
  input  core_pkg::opcode_e    es2ws_op,
  input  core_pkg::reg_idx_t   es2ws_rd,
  input  core_pkg::word_t      es2ws_result,
  output logic                 ws_allowin,
  input  logic                 data_data_ok,
  input  core_pkg::word_t      data_rdata,
  output logic                 ws_dest_valid,
  output core_pkg::reg_idx_t   ws_dest,
  output logic                 rf_we,
  output core_pkg::reg_idx_t   rf_waddr,
  output core_pkg::word_t      rf_wdata,
  output logic                 debug_wb_valid,
  output core_pkg::word_t      debug_wb_pc,
  output logic                 debug_wb_rf_we,
  output core_pkg::reg_idx_t   debug_wb_rf_wnum,
  output core_pkg::word_t      debug_wb_rf_wdata
);

  logic               ws_valid;
  core_pkg::word_t    ws_pc;
  core_pkg::opcode_e  ws_op;
  core_pkg::reg_idx_t ws_rd;
  core_pkg::word_t    ws_result;
  logic               is_load;
  logic               ws_ready_go;

  // a store's data_ok can show up here, but only a waiting load looks at it
  assign is_load     = ws_op == core_pkg::op_lw;
  assign ws_ready_go = !is_load || data_data_ok;
  assign ws_allowin  = !ws_valid || ws_ready_go;

  assign ws_dest_valid = ws_valid && core_pkg::writes_rd(ws_op) && ws_rd != '0;
  assign ws_dest       = ws_rd;

  assign rf_we    = ws_dest_valid && ws_ready_go;
  assign rf_waddr = ws_rd;
  assign rf_wdata = is_load ? data_rdata : ws_result;

  assign debug_wb_valid    = ws_valid && ws_ready_go;
  assign debug_wb_pc       = ws_pc;
  assign debug_wb_rf_we    = rf_we;
  assign debug_wb_rf_wnum  = rf_waddr;
  assign debug_wb_rf_wdata = rf_wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      ws_valid <= 1'b0;
    end else if (ws_allowin) begin
      ws_valid <= es2ws_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (es2ws_valid && ws_allowin) begin
      ws_pc     <= es2ws_pc;
      ws_op     <= es2ws_op;
      ws_rd     <= es2ws_rd;
      ws_result <= es2ws_result;
    end
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns
module reg_file (
  input  logic               clk,
  input  core_pkg::reg_idx_t raddr1,
  input  core_pkg::reg_idx_t raddr2,
  output core_pkg::word_t    rdata1,
  output core_pkg::word_t    rdata2,
  input  logic               we,
  input  core_pkg::reg_idx_t waddr,
  input  core_pkg::word_t    wdata
);

  core_pkg::word_t regs [16];  // entry 0 is never written nor read

  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // reads see the value before a same-cycle write
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- logic/sram_bus_arbiter.sv
`timescale 1ns/1ns
module sram_bus_arbiter (
  input  logic            clk,
  input  logic            reset,
  input  logic            inst_req,
  input  core_pkg::word_t inst_addr,
  output logic            inst_addr_ok,
  output logic            inst_data_ok,
  output core_pkg::word_t inst_rdata,
  input  logic            data_req,
  input  logic            data_wr,
  input  core_pkg::word_t data_addr,
  input  core_pkg::word_t data_wdata,
  output logic            data_addr_ok,
  output logic            data_data_ok,
  output core_pkg::word_t data_rdata,
  output logic            bus_req,
  output logic            bus_wr,
  output core_pkg::word_t bus_addr,
  output core_pkg::word_t bus_wdata,
  input  logic            bus_addr_ok,
  input  logic            bus_data_ok,
  input  core_pkg::word_t bus_rdata
);

  core_pkg::bus_owner_e order_q [2];
  logic                 rd_ptr;
  logic                 wr_ptr;
  logic [1:0]           cnt;
  logic                 lock_q;      // a bus request is waiting, keep its owner
  core_pkg::bus_owner_e lock_owner;
  logic                 inst_pend;
  logic                 data_pend;
  logic                 sel_data;
  logic                 push;

  // a master with a response still due is not granted again
  always_comb begin
    inst_pend = 1'b0;
    data_pend = 1'b0;
    for (int i = 0; i < 2; i++) begin
      if (cnt == 2'd2 || (cnt == 2'd1 && i == int'(rd_ptr))) begin
        if (order_q[i] == core_pkg::owner_data) begin
          data_pend = 1'b1;
        end else begin
          inst_pend = 1'b1;
        end
      end
    end
  end

  assign sel_data  = lock_q ? (lock_owner == core_pkg::owner_data) : (data_req && !data_pend);
  assign bus_req   = lock_q || (data_req && !data_pend) || (inst_req && !inst_pend);
  assign bus_wr    = sel_data && data_wr;
  assign bus_addr  = sel_data ? data_addr : inst_addr;
  assign bus_wdata = data_wdata;
  assign push      = bus_req && bus_addr_ok;

  assign data_addr_ok = push && sel_data;
  assign inst_addr_ok = push && !sel_data;
  assign data_data_ok = bus_data_ok && order_q[rd_ptr] == core_pkg::owner_data;
  assign inst_data_ok = bus_data_ok && order_q[rd_ptr] == core_pkg::owner_fetch;
  assign data_rdata   = bus_rdata;
  assign inst_rdata   = bus_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= 1'b0;
      wr_ptr <= 1'b0;
      cnt    <= 2'd0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= bus_req && !bus_addr_ok;
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (bus_data_ok) begin
        rd_ptr <= !rd_ptr;
      end
      cnt <= cnt + 2'(push) - 2'(bus_data_ok);
    end
  end

  always_ff @(posedge clk) begin
    lock_owner <= sel_data ? core_pkg::owner_data : core_pkg::owner_fetch;
    if (push) begin
      order_q[wr_ptr] <= sel_data ? core_pkg::owner_data : core_pkg::owner_fetch;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push && !bus_data_ok |-> cnt != 2'd2);

  a_no_orphan_data_ok: assert property (@(posedge clk) disable iff (reset)
    bus_data_ok |-> cnt != 2'd0);

endmodule

//--- logic/core_top.sv
`timescale 1ns/1ns
module core_top (
  input  logic               clk,
  input  logic               reset,
  output logic               bus_req,
  output logic               bus_wr,
  output core_pkg::word_t    bus_addr,
  output core_pkg::word_t    bus_wdata,
  input  logic               bus_addr_ok,
  input  logic               bus_data_ok,
  input  core_pkg::word_t    bus_rdata,
  output logic               debug_wb_valid,
  output core_pkg::word_t    debug_wb_pc,
  output logic               debug_wb_rf_we,
  output core_pkg::reg_idx_t debug_wb_rf_wnum,
  output core_pkg::word_t    debug_wb_rf_wdata
);

  logic inst_req, inst_addr_ok, inst_data_ok;
  core_pkg::word_t inst_addr, inst_rdata;
  logic data_req, data_wr, data_addr_ok, data_data_ok;
  core_pkg::word_t data_addr, data_wdata, data_rdata;
  logic redirect;
  core_pkg::word_t redirect_pc;
  logic ds_allowin, es_allowin, ws_allowin;
  logic fs2ds_valid, ds2es_valid, es2ws_valid;
  core_pkg::word_t fs2ds_pc, fs2ds_inst;
  core_pkg::word_t ds2es_pc, ds2es_a, ds2es_b, ds2es_imm;
  core_pkg::opcode_e ds2es_op, es2ws_op;
  core_pkg::reg_idx_t ds2es_rd, es2ws_rd;
  core_pkg::word_t es2ws_pc, es2ws_result;
  core_pkg::reg_idx_t rf_raddr1, rf_raddr2, rf_waddr;
  core_pkg::word_t rf_rdata1, rf_rdata2, rf_wdata;
  logic rf_we;
  logic es_dest_valid, ws_dest_valid;
  core_pkg::reg_idx_t es_dest, ws_dest;

  fetch_stage u_fetch (
    .clk         (clk),
    .reset       (reset),
    .inst_req    (inst_req),
    .inst_addr   (inst_addr),
    .inst_addr_ok(inst_addr_ok),
    .inst_data_ok(inst_data_ok),
    .inst_rdata  (inst_rdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ds_allowin  (ds_allowin),
    .fs2ds_valid (fs2ds_valid),
    .fs2ds_pc    (fs2ds_pc),
    .fs2ds_inst  (fs2ds_inst)
  );

  decode_stage u_decode (
    .clk          (clk),
    .reset        (reset),
    .fs2ds_valid  (fs2ds_valid),
    .fs2ds_pc     (fs2ds_pc),
    .fs2ds_inst   (fs2ds_inst),
    .ds_allowin   (ds_allowin),
    .flush        (redirect),
    .rf_raddr1    (rf_raddr1),
    .rf_raddr2    (rf_raddr2),
    .rf_rdata1    (rf_rdata1),
    .rf_rdata2    (rf_rdata2),
    .es_dest_valid(es_dest_valid),
    .es_dest      (es_dest),
    .ws_dest_valid(ws_dest_valid),
    .ws_dest      (ws_dest),
    .es_allowin   (es_allowin),
    .ds2es_valid  (ds2es_valid),
    .ds2es_pc     (ds2es_pc),
    .ds2es_op     (ds2es_op),
    .ds2es_rd     (ds2es_rd),
    .ds2es_a      (ds2es_a),
    .ds2es_b      (ds2es_b),
    .ds2es_imm    (ds2es_imm)
  );

  exec_stage u_exec (
    .clk          (clk),
    .reset        (reset),
    .ds2es_valid  (ds2es_valid),
    .ds2es_pc     (ds2es_pc),
    .ds2es_op     (ds2es_op),
    .ds2es_rd     (ds2es_rd),
    .ds2es_a      (ds2es_a),
    .ds2es_b      (ds2es_b),
    .ds2es_imm    (ds2es_imm),
    .es_allowin   (es_allowin),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .data_req     (data_req),
    .data_wr      (data_wr),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_addr_ok (data_addr_ok),
    .es_dest_valid(es_dest_valid),
    .es_dest      (es_dest),
    .ws_allowin   (ws_allowin),
    .es2ws_valid  (es2ws_valid),
    .es2ws_pc     (es2ws_pc),
    .es2ws_op     (es2ws_op),
    .es2ws_rd     (es2ws_rd),
    .es2ws_result (es2ws_result)
  );

  writeback_stage u_writeback (
    .clk              (clk),
    .reset            (reset),
    .es2ws_valid      (es2ws_valid),
    .es2ws_pc         (es2ws_pc),
    .es2ws_op         (es2ws_op),
    .es2ws_rd         (es2ws_rd),
    .es2ws_result     (es2ws_result),
    .ws_allowin       (ws_allowin),
    .data_data_ok     (data_data_ok),
    .data_rdata       (data_rdata),
    .ws_dest_valid    (ws_dest_valid),
    .ws_dest          (ws_dest),
    .rf_we            (rf_we),
    .rf_waddr         (rf_waddr),
    .rf_wdata         (rf_wdata),
    .debug_wb_valid   (debug_wb_valid),
    .debug_wb_pc      (debug_wb_pc),
    .debug_wb_rf_we   (debug_wb_rf_we),
    .debug_wb_rf_wnum (debug_wb_rf_wnum),
    .debug_wb_rf_wdata(debug_wb_rf_wdata)
  );

  reg_file u_reg_file (
    .clk   (clk),
    .raddr1(rf_raddr1),
    .raddr2(rf_raddr2),
    .rdata1(rf_rdata1),
    .rdata2(rf_rdata2),
    .we    (rf_we),
    .waddr (rf_waddr),
    .wdata (rf_wdata)
  );

  sram_bus_arbiter u_arbiter (
    .clk         (clk),
    .reset       (reset),
    .inst_req    (inst_req),
    .inst_addr   (inst_addr),
    .inst_addr_ok(inst_addr_ok),
    .inst_data_ok(inst_data_ok),
    .inst_rdata  (inst_rdata),
    .data_req    (data_req),
    .data_wr     (data_wr),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_addr_ok(data_addr_ok),
    .data_data_ok(data_data_ok),
    .data_rdata  (data_rdata),
    .bus_req     (bus_req),
    .bus_wr      (bus_wr),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_addr_ok (bus_addr_ok),
    .bus_data_ok (bus_data_ok),
    .bus_rdata   (bus_rdata)
  );

endmodule

//--- sim/core_top_tb.sv
`timescale 1ns/1ns
module core_top_tb;

  localparam int prog_len       = 200;
  localparam int timeout_cycles = prog_len * 40;
  localparam int n_tests        = 6;
  localparam int t_trace        = 0;
  localparam int t_alu          = 1;
  localparam int t_dep          = 2;
  localparam int t_load         = 3;
  localparam int t_store        = 4;
  localparam int t_answer       = 5;
  localparam core_pkg::word_t data_base = 32'h0000_1000;

  logic               clk = 1'b0;
  logic               reset;
  logic               bus_req;
  logic               bus_wr;
  core_pkg::word_t    bus_addr;
  core_pkg::word_t    bus_wdata;
  logic               bus_addr_ok;
  logic               bus_data_ok;
  core_pkg::word_t    bus_rdata;
  logic               debug_wb_valid;
  core_pkg::word_t    debug_wb_pc;
  logic               debug_wb_rf_we;
  core_pkg::reg_idx_t debug_wb_rf_wnum;
  core_pkg::word_t    debug_wb_rf_wdata;

  integer          seed;
  core_pkg::word_t prog [prog_len];
  core_pkg::word_t bus_mem [64];    // data window as the DUT sees it
  core_pkg::word_t model_mem [64];
  core_pkg::word_t model_regs [16];

  // expected retirement stream in program order
  core_pkg::word_t    exp_pc [prog_len];
  logic               exp_we [prog_len];
  core_pkg::reg_idx_t exp_wnum [prog_len];
  core_pkg::word_t    exp_wdata [prog_len];
  int                 exp_test [prog_len];
  int                 exp_n;
  int                 ret_idx;

  core_pkg::word_t store_addr_q [$];
  core_pkg::word_t store_data_q [$];
  int              resp_due [$];      // cycle in which each data_ok is driven
  core_pkg::word_t resp_data [$];
  logic            resp_load [$];     // set where the response answers a load
  logic            load_answer_due;
  int              accept_wait;
  int              cycle_cnt;

  int    checks [n_tests];
  int    errors [n_tests];
  string test_name [n_tests];

  core_top u_core_top (
    .clk              (clk),
    .reset            (reset),
    .bus_req          (bus_req),
    .bus_wr           (bus_wr),
    .bus_addr         (bus_addr),
    .bus_wdata        (bus_wdata),
    .bus_addr_ok      (bus_addr_ok),
    .bus_data_ok      (bus_data_ok),
    .bus_rdata        (bus_rdata),
    .debug_wb_valid   (debug_wb_valid),
    .debug_wb_pc      (debug_wb_pc),
    .debug_wb_rf_we   (debug_wb_rf_we),
    .debug_wb_rf_wnum (debug_wb_rf_wnum),
    .debug_wb_rf_wdata(debug_wb_rf_wdata)
  );

  always #50 clk = ~clk;

  function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic core_pkg::word_t encode(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [3:0] rs1, input logic [3:0] rs2,
                                             input logic [15:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  function automatic logic in_window(input core_pkg::word_t addr);
    return addr >= data_base && addr < data_base + 32'd256;
  endfunction

  function automatic int word_index(input core_pkg::word_t addr);
    return int'(((addr - data_base) >> 2) & 32'd63);
  endfunction

  task automatic compare_word(input int t, input core_pkg::word_t expected,
                              input core_pkg::word_t actual);
    checks[t]++;
    if (actual !== expected) begin
      errors[t]++;
      $display("FAILED %s: expected %h, actual %h", test_name[t], expected, actual);
    end
  endtask

  task automatic compare_reg(input int t, input core_pkg::reg_idx_t expected,
                             input core_pkg::reg_idx_t actual);
    checks[t]++;
    if (actual !== expected) begin
      errors[t]++;
      $display("FAILED %s: expected r%0d, actual r%0d", test_name[t], expected, actual);
    end
  endtask

  task automatic compare_bit(input int t, input logic expected, input logic actual);
    checks[t]++;
    if (actual !== expected) begin
      errors[t]++;
      $display("FAILED %s: expected we %b, actual we %b", test_name[t], expected, actual);
    end
  endtask

  task automatic build_program();
    logic [3:0]         kind_op;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::reg_idx_t last_rd;
    logic [15:0]        imm;
    logic [15:0]        slot;
    int                 kind;
    last_rd = '0;
    for (int i = 0; i < 15; i++) begin
      prog[i] = encode(core_pkg::op_addi, 4'(i + 1), 4'h0, 4'h0, 16'(pick(65536)));
    end
    for (int i = 15; i < prog_len; i++) begin
      kind = pick(20);
      rd   = 4'(pick(16));
      rs1  = (pick(2) == 1) ? last_rd : 4'(pick(16));  // favor back-to-back dependencies
      rs2  = 4'(pick(16));
      imm  = 16'(pick(65536));
      slot = 16'(data_base) + 16'(pick(64) * 4);
      if (kind < 8) begin
        kind_op = 4'(pick(5));  // add through xor
        prog[i] = encode(kind_op, rd, rs1, rs2, imm);
        last_rd = rd;
      end else if (kind < 11) begin
        prog[i] = encode(core_pkg::op_addi, rd, rs1, rs2, imm);
        last_rd = rd;
      end else if (kind < 14) begin
        prog[i] = encode(core_pkg::op_lw, rd, 4'h0, rs2, slot);
        last_rd = rd;
      end else if (kind < 17) begin
        prog[i] = encode(core_pkg::op_sw, rd, 4'h0, rs1, slot);
      end else if (kind < 19) begin
        rs2 = (pick(2) == 1) ? rs1 : rs2;
        prog[i] = encode(core_pkg::op_beq, rd, rs1, rs2, 16'(1 + pick(4)));
      end else begin
        prog[i] = encode(4'(9 + pick(7)), rd, rs1, rs2, imm);
      end
    end
    for (int k = 0; k < 64; k++) begin
      bus_mem[k]   = $random(seed);
      model_mem[k] = bus_mem[k];
    end
  endtask

  task automatic run_model();
    core_pkg::word_t    pc;
    core_pkg::word_t    inst;
    core_pkg::word_t    a;
    core_pkg::word_t    b;
    core_pkg::word_t    imm;
    core_pkg::word_t    res;
    core_pkg::word_t    next_pc;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::reg_idx_t prev_dest;
    logic [3:0]         op;
    logic               writes;
    logic               uses_rs2;
    pc        = 32'h0;
    exp_n     = 0;
    prev_dest = '0;
    for (int r = 0; r < 16; r++) begin
      model_regs[r] = '0;
    end
    while (pc < prog_len * 4) begin
      inst    = prog[pc >> 2];
      op      = inst[31:28];
      rd      = inst[27:24];
      rs1     = inst[23:20];
      rs2     = inst[19:16];
      imm     = {{16{inst[15]}}, inst[15:0]};
      a       = model_regs[rs1];
      b       = model_regs[rs2];
      res     = '0;
      next_pc = pc + 32'd4;
      case (op)
        core_pkg::op_add:  res = a + b;
        core_pkg::op_sub:  res = a - b;
        core_pkg::op_and:  res = a & b;
        core_pkg::op_or:   res = a | b;
        core_pkg::op_xor:  res = a ^ b;
        core_pkg::op_addi: res = a + imm;
        core_pkg::op_lw:   res = model_mem[word_index(a + imm)];
        core_pkg::op_sw: begin
          model_mem[word_index(a + imm)] = b;
          store_addr_q.push_back(a + imm);
          store_data_q.push_back(b);
        end
        core_pkg::op_beq: begin
          if (a == b) begin
            next_pc = pc + 32'd4 + (imm << 2);
          end
        end
        default: ;
      endcase
      writes   = op inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
                            core_pkg::op_or, core_pkg::op_xor, core_pkg::op_addi,
                            core_pkg::op_lw};
      uses_rs2 = op inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
                            core_pkg::op_or, core_pkg::op_xor};
      exp_pc[exp_n]    = pc;
      exp_we[exp_n]    = writes && rd != '0;
      exp_wnum[exp_n]  = rd;
      exp_wdata[exp_n] = res;
      if (op == core_pkg::op_lw) begin
        exp_test[exp_n] = t_load;
      end else if (writes && prev_dest != '0 &&
                   (rs1 == prev_dest || (uses_rs2 && rs2 == prev_dest))) begin
        exp_test[exp_n] = t_dep;  // reads the result of the instruction just before
      end else if (writes) begin
        exp_test[exp_n] = t_alu;
      end else begin
        exp_test[exp_n] = t_trace;
      end
      if (writes && rd != '0) begin
        model_regs[rd] = res;
      end
      prev_dest = writes ? rd : 4'h0;
      exp_n++;
      pc = next_pc;
    end
  endtask

  task automatic serve_request();
    core_pkg::word_t rdata;
    rdata = '0;
    if (bus_wr) begin
      if (store_addr_q.size() == 0) begin
        checks[t_store]++;
        errors[t_store]++;
        $display("unexpected bus write to %h with data %h", bus_addr, bus_wdata);
      end else begin
        compare_word(t_store, store_addr_q.pop_front(), bus_addr);
        compare_word(t_store, store_data_q.pop_front(), bus_wdata);
      end
      if (in_window(bus_addr)) begin
        bus_mem[word_index(bus_addr)] = bus_wdata;
      end
    end else if (bus_addr < prog_len * 4) begin
      rdata = prog[bus_addr >> 2];
    end else if (in_window(bus_addr)) begin
      rdata = bus_mem[word_index(bus_addr)];
    end else begin
      rdata = {4'hF, bus_addr[27:0]};  // past the program every word is a no-op
    end
    resp_due.push_back(cycle_cnt + 1 + pick(4));
    resp_data.push_back(rdata);
    resp_load.push_back(!bus_wr && in_window(bus_addr));
  endtask

  // the shared memory accepts in 0 to 3 cycles and answers in order 1 to 4 cycles later
  always @(negedge clk) begin
    bus_addr_ok     = 1'b0;
    bus_data_ok     = 1'b0;
    load_answer_due = 1'b0;
    if (!reset) begin
      if (resp_due.size() > 0 && resp_due[0] <= cycle_cnt) begin
        bus_data_ok     = 1'b1;
        bus_rdata       = resp_data.pop_front();
        load_answer_due = resp_load.pop_front();
        void'(resp_due.pop_front());
      end
      if (bus_req === 1'b1) begin
        if (accept_wait < 0) begin
          accept_wait = pick(4);
        end
        if (accept_wait == 0) begin
          bus_addr_ok = 1'b1;
          accept_wait = -1;
          serve_request();
        end else begin
          accept_wait--;
        end
      end
    end
  end

  always @(posedge clk) begin
    // a load retires in the same cycle its data comes back
    if (!reset && load_answer_due) begin
      checks[t_answer]++;
      if (debug_wb_valid !== 1'b1) begin
        errors[t_answer]++;
        $display("load data came back at %0t but no instruction retired with it", $time);
      end
    end
    if (!reset && debug_wb_valid === 1'b1 && ret_idx < exp_n) begin
      compare_word(t_trace, exp_pc[ret_idx], debug_wb_pc);
      compare_bit(exp_test[ret_idx], exp_we[ret_idx], debug_wb_rf_we);
      if (exp_we[ret_idx]) begin
        compare_reg(exp_test[ret_idx], exp_wnum[ret_idx], debug_wb_rf_wnum);
        compare_word(exp_test[ret_idx], exp_wdata[ret_idx], debug_wb_rf_wdata);
      end
      ret_idx++;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with %0d of %0d instructions retired",
             cycle_cnt, ret_idx, exp_n);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int total_checks;
    int total_errors;
    int failed_tests;
    reset           = 1'b1;
    bus_addr_ok     = 1'b0;
    bus_data_ok     = 1'b0;
    bus_rdata       = '0;
    load_answer_due = 1'b0;
    accept_wait     = -1;
    ret_idx         = 0;
    seed            = 32'h8f2;
    test_name       = '{"retire_trace", "alu_result", "dependent_result",
                        "load_value", "bus_store", "data_ok_answer"};
    build_program();
    run_model();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    wait (ret_idx == exp_n);
    checks[t_store]++;
    if (store_addr_q.size() > 0) begin
      errors[t_store]++;
      $display("%0d expected stores never appeared on the bus", store_addr_q.size());
    end

    total_checks = 0;
    total_errors = 0;
    failed_tests = 0;
    for (int t = 0; t < n_tests; t++) begin
      if (checks[t] == 0) begin
        errors[t]++;
        $display("test %s ran no checks", test_name[t]);
      end
      $display("test %s: %0d checks, %0d errors, %s", test_name[t], checks[t], errors[t],
               (errors[t] == 0) ? "passed" : "failed");
      total_checks += checks[t];
      total_errors += errors[t];
      if (errors[t] != 0) begin
        failed_tests++;
      end
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d instructions retired",
             n_tests, failed_tests, total_checks, total_errors, ret_idx);
    if (total_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- core_top.f
logic/core_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/writeback_stage.sv
logic/reg_file.sv
logic/sram_bus_arbiter.sv
logic/core_top.sv
sim/core_top_tb.sv
